// File: rtl/wb_pkg.sv
//********************
// Shared write-back types; big-endian bit order, bit 0 is the MSB
// CR0 field order is lt, gt, eq, so
//********************

package wb_pkg;

    localparam int RS_ID_WIDTH = 5;

    typedef logic [0:RS_ID_WIDTH-1] rs_id_t;
    typedef logic [0:4]             gpr_addr_t;
    typedef logic [0:9]             spr_addr_t;
    typedef logic [0:31]            word_t;
    typedef logic [0:3]             cr_field_t;

    // XER lives at SPR address 1
    localparam spr_addr_t XER_SPR_ADDR = 10'd1;

    // Result offered by one GPR execution unit
    typedef struct packed {
        rs_id_t    rs_id;
        gpr_addr_t reg_addr;
        word_t     result;
        logic      xer_valid;
        word_t     xer;
        logic      cr0_valid;
        logic      so;
    } gpr_result_t;

    // Result offered by the SPR unit
    typedef struct packed {
        rs_id_t    rs_id;
        spr_addr_t addr;
        word_t     result;
    } spr_result_t;

    typedef struct packed {
        logic      valid;
        rs_id_t    rs_id;
        gpr_addr_t reg_addr;
        word_t     result;
    } gpr_wb_t;

    typedef struct packed {
        logic      valid;
        rs_id_t    rs_id;
        spr_addr_t addr;
        word_t     result;
    } spr_wb_t;

    typedef struct packed {
        logic      valid;
        rs_id_t    rs_id;
        cr_field_t field;
    } cr_wb_t;

    // Who owns the SPR write port on the next contended cycle
    typedef enum logic {
        gpr_turn,
        spr_turn
    } spr_turn_e;

    // Signed compare against zero, with so copied into the last bit
    function automatic cr_field_t cr0_of(word_t result, logic so);
        logic lt;
        logic eq;
        lt = result[0];
        eq = (result == '0);
        return {lt, ~lt & ~eq, eq, so};
    endfunction

endpackage

// File: rtl/wb_turn_fsm.sv
//********************
// Grants are combinational from the valid inputs; only the turn is stored
//********************
`timescale 1ns/100ps

module wb_turn_fsm (
    input  logic clk,
    input  logic rst,
    input  logic spr_valid,
    input  logic any_found,
    input  logic clean_found,
    output logic grant_any,
    output logic grant_clean,
    output logic grant_spr
);

    import wb_pkg::*;

    spr_turn_e turn_q;
    spr_turn_e turn_d;

    always_comb begin
        grant_any   = 1'b0;
        grant_clean = 1'b0;
        grant_spr   = 1'b0;
        turn_d      = turn_q;

        if (!spr_valid) begin
            // No SPR request, the port is free for any GPR side effect
            grant_any = any_found;
        end else if (turn_q == spr_turn) begin
            grant_spr   = 1'b1;
            grant_clean = clean_found;
            turn_d      = gpr_turn;
        end else begin
            if (clean_found) begin
                // Pair a GPR result that leaves XER alone with the SPR result
                grant_clean = 1'b1;
                grant_spr   = 1'b1;
            end else begin
                grant_any = any_found;
                grant_spr = ~any_found;
            end
            turn_d = spr_turn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn_q <= gpr_turn;
        end else begin
            turn_q <= turn_d;
        end
    end

endmodule

// File: rtl/rr_pointer.sv
//********************
// Start index for the round-robin search
//********************
`timescale 1ns/100ps

module rr_pointer #(
    parameter int NUM_UNITS = 8,
    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             gpr_grant,
    input  logic [0:IDX_W-1] gpr_grant_idx,
    output logic [0:IDX_W-1] start_idx
);

    logic [0:IDX_W-1] next_idx;

    // Wrap to unit 0 after the last unit
    assign next_idx = (int'(gpr_grant_idx) == NUM_UNITS - 1) ? '0 : gpr_grant_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_idx <= '0;
        end else if (gpr_grant) begin
            start_idx <= next_idx;
        end
    end

endmodule

// File: rtl/gpr_search.sv
//********************
// Pure combinational; the indices are only meaningful when the found flags are set
//********************
`timescale 1ns/100ps

module gpr_search #(
    parameter int NUM_UNITS = 8,
    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
    input  logic [0:NUM_UNITS-1] gpr_valid,
    input  logic [0:NUM_UNITS-1] xer_valid,
    input  logic [0:IDX_W-1]     start_idx,
    output logic                 any_found,
    output logic [0:IDX_W-1]     any_idx,
    output logic                 clean_found,
    output logic [0:IDX_W-1]     clean_idx
);

    always_comb begin
        int cur;

        any_found   = 1'b0;
        any_idx     = start_idx;
        clean_found = 1'b0;
        clean_idx   = start_idx;

        // Walk the units in rotated order, the first hit wins
        for (int i = 0; i < NUM_UNITS; i++) begin
            cur = (int'(start_idx) + i) % NUM_UNITS;

            if (gpr_valid[cur] && !any_found) begin
                any_found = 1'b1;
                any_idx   = IDX_W'(cur);
            end

            // Units without an XER update can share the SPR port cycle
            if (gpr_valid[cur] && !xer_valid[cur] && !clean_found) begin
                clean_found = 1'b1;
                clean_idx   = IDX_W'(cur);
            end
        end
    end

endmodule

// File: rtl/wb_route.sv
//********************
// Ready strobes are same-cycle; write-back ports are registered one cycle later
// grant_any and grant_clean are never high together
//********************
`timescale 1ns/100ps

module wb_route #(
    parameter int NUM_UNITS = 8,
    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                grant_any,
    input  logic                grant_clean,
    input  logic                grant_spr,

    input  logic [0:IDX_W-1]    any_idx,
    input  logic [0:IDX_W-1]    clean_idx,

    input  wb_pkg::gpr_result_t gpr_in [0:NUM_UNITS-1],
    input  wb_pkg::spr_result_t spr_in,

    output logic [0:NUM_UNITS-1] gpr_ready,
    output logic                 spr_ready,

    output logic                gpr_grant,
    output logic [0:IDX_W-1]    gpr_grant_idx,

    output wb_pkg::gpr_wb_t     gpr_out,
    output wb_pkg::spr_wb_t     spr_out,
    output wb_pkg::cr_wb_t      cr_out
);

    import wb_pkg::*;

    gpr_result_t entry;
    gpr_wb_t     gpr_d;
    spr_wb_t     spr_d;
    cr_wb_t      cr_d;

    assign gpr_grant     = grant_any | grant_clean;
    assign gpr_grant_idx = grant_clean ? clean_idx : any_idx;
    assign spr_ready     = grant_spr;
    assign entry         = gpr_in[gpr_grant_idx];

    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            gpr_ready[i] = gpr_grant && (int'(gpr_grant_idx) == i);
        end
    end

    always_comb begin
        gpr_d.valid    = gpr_grant;
        gpr_d.rs_id    = entry.rs_id;
        gpr_d.reg_addr = entry.reg_addr;
        gpr_d.result   = entry.result;

        // SPR unit result takes the port, otherwise an XER side effect may use it
        if (grant_spr) begin
            spr_d.valid  = 1'b1;
            spr_d.rs_id  = spr_in.rs_id;
            spr_d.addr   = spr_in.addr;
            spr_d.result = spr_in.result;
        end else begin
            spr_d.valid  = gpr_grant & entry.xer_valid;
            spr_d.rs_id  = entry.rs_id;
            spr_d.addr   = XER_SPR_ADDR;
            spr_d.result = entry.xer;
        end

        cr_d.valid = gpr_grant & entry.cr0_valid;
        cr_d.rs_id = entry.rs_id;
        cr_d.field = cr0_of(entry.result, entry.so);
    end

    always_ff @(posedge clk) begin
        gpr_out <= gpr_d;
        spr_out <= spr_d;
        cr_out  <= cr_d;
        if (rst) begin
            gpr_out.valid <= 1'b0;
            spr_out.valid <= 1'b0;
            cr_out.valid  <= 1'b0;
        end
    end

endmodule

// File: rtl/wb_arbiter_top.sv
//********************
// One GPR grant per cycle; units hold valid and data until their ready strobe
//********************
`timescale 1ns/100ps

module wb_arbiter_top #(
    parameter int NUM_UNITS = 8,
    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [0:NUM_UNITS-1] gpr_valid,
    output logic [0:NUM_UNITS-1] gpr_ready,
    input  wb_pkg::gpr_result_t  gpr_in [0:NUM_UNITS-1],

    input  logic                 spr_valid,
    output logic                 spr_ready,
    input  wb_pkg::spr_result_t  spr_in,

    output wb_pkg::gpr_wb_t      gpr_out,
    output wb_pkg::spr_wb_t      spr_out,
    output wb_pkg::cr_wb_t       cr_out
);

    logic [0:NUM_UNITS-1] xer_bits;
    logic [0:IDX_W-1]     start_idx;
    logic [0:IDX_W-1]     any_idx;
    logic [0:IDX_W-1]     clean_idx;
    logic [0:IDX_W-1]     gpr_grant_idx;
    logic                 any_found;
    logic                 clean_found;
    logic                 grant_any;
    logic                 grant_clean;
    logic                 grant_spr;
    logic                 gpr_grant;

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_xer_bits
        assign xer_bits[i] = gpr_in[i].xer_valid;
    end

    rr_pointer #(.NUM_UNITS(NUM_UNITS)) u_rr_pointer (
        .clk(clk), .rst(rst),
        .gpr_grant(gpr_grant), .gpr_grant_idx(gpr_grant_idx),
        .start_idx(start_idx)
    );

    gpr_search #(.NUM_UNITS(NUM_UNITS)) u_gpr_search (
        .gpr_valid(gpr_valid), .xer_valid(xer_bits), .start_idx(start_idx),
        .any_found(any_found), .any_idx(any_idx),
        .clean_found(clean_found), .clean_idx(clean_idx)
    );

    wb_turn_fsm u_wb_turn_fsm (
        .clk(clk), .rst(rst),
        .spr_valid(spr_valid), .any_found(any_found), .clean_found(clean_found),
        .grant_any(grant_any), .grant_clean(grant_clean), .grant_spr(grant_spr)
    );

    wb_route #(.NUM_UNITS(NUM_UNITS)) u_wb_route (
        .clk(clk), .rst(rst),
        .grant_any(grant_any), .grant_clean(grant_clean), .grant_spr(grant_spr),
        .any_idx(any_idx), .clean_idx(clean_idx),
        .gpr_in(gpr_in), .spr_in(spr_in),
        .gpr_ready(gpr_ready), .spr_ready(spr_ready),
        .gpr_grant(gpr_grant), .gpr_grant_idx(gpr_grant_idx),
        .gpr_out(gpr_out), .spr_out(spr_out), .cr_out(cr_out)
    );

endmodule

// File: tb/tb_wb_arbiter.sv
//********************
// Expected grants in the table assume NUM_UNITS of 4 and start from reset
//********************
`timescale 1ns/100ps

module tb_wb_arbiter;

    import wb_pkg::*;

    localparam int N          = 4;
    localparam int CLK_PERIOD = 100;

    // One table row, mode 0 random results, 1 zero results, 2 negative results
    typedef struct packed {
        logic [0:N-1] gv;
        logic [0:N-1] xer;
        logic [0:N-1] cr0;
        logic         spr;
        logic [1:0]   mode;
        logic [0:N-1] exp_ready;
        logic         exp_spr;
    } row_t;

    logic         clk;
    logic         rst;
    logic [0:N-1] gpr_valid;
    logic [0:N-1] gpr_ready;
    gpr_result_t  gpr_in [0:N-1];
    logic         spr_valid;
    logic         spr_ready;
    spr_result_t  spr_in;
    gpr_wb_t      gpr_out;
    spr_wb_t      spr_out;
    cr_wb_t       cr_out;

    row_t    rows[$];
    string   names[$];
    bit      table_built;
    int      errors;
    int      failed_tests;
    gpr_wb_t exp_gpr;
    spr_wb_t exp_spr;
    cr_wb_t  exp_cr;

    wb_arbiter_top #(.NUM_UNITS(N)) uut (
        .clk(clk), .rst(rst),
        .gpr_valid(gpr_valid), .gpr_ready(gpr_ready), .gpr_in(gpr_in),
        .spr_valid(spr_valid), .spr_ready(spr_ready), .spr_in(spr_in),
        .gpr_out(gpr_out), .spr_out(spr_out), .cr_out(cr_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Sign and zero test of the result, so in the last bit
    function automatic cr_field_t cr0_model(word_t value, logic so);
        if (value == 32'd0) return {3'b001, so};
        if ($signed(value) < 0) return {3'b100, so};
        return {3'b010, so};
    endfunction

    task automatic compare_value(string test, string what, logic [63:0] expected,
                                 logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    // Payload only matters when the port is expected to be written
    task automatic compare_port(string test, string what, logic exp_valid,
                                logic [63:0] expected, logic act_valid, logic [63:0] actual);
        if (exp_valid) begin
            compare_value(test, what, expected, actual);
        end else begin
            compare_value(test, {what, ".valid"}, 1'b0, act_valid);
        end
    endtask

    task automatic add_row(string name, logic [0:N-1] gv, logic [0:N-1] xer,
                           logic [0:N-1] cr0, logic spr, logic [1:0] mode,
                           logic [0:N-1] exp_ready, logic exp_spr);
        rows.push_back('{gv, xer, cr0, spr, mode, exp_ready, exp_spr});
        names.push_back(name);
    endtask

    task automatic drive_row(row_t row);
        for (int i = 0; i < N; i++) begin
            gpr_in[i].rs_id     = rs_id_t'(i + 1);
            gpr_in[i].reg_addr  = gpr_addr_t'($urandom);
            gpr_in[i].result    = (row.mode == 2'd1) ? 32'd0 :
                                  (row.mode == 2'd2) ? ($urandom | 32'h8000_0000) : $urandom;
            gpr_in[i].xer_valid = row.xer[i];
            gpr_in[i].xer       = $urandom;
            gpr_in[i].cr0_valid = row.cr0[i];
            gpr_in[i].so        = 1'($urandom);
        end
        spr_in.rs_id  = rs_id_t'(20);
        spr_in.addr   = spr_addr_t'($urandom);
        spr_in.result = $urandom;
        gpr_valid     = row.gv;
        spr_valid     = row.spr;
    endtask

    // Write-backs due one cycle later, from the unit the table marks ready
    task automatic build_expected(row_t row);
        gpr_result_t entry;
        logic        granted;
        entry   = '0;
        granted = 1'b0;
        exp_gpr = '0;
        exp_spr = '0;
        exp_cr  = '0;
        for (int i = 0; i < N; i++) begin
            if (row.exp_ready[i]) begin
                entry   = gpr_in[i];
                granted = 1'b1;
            end
        end
        if (granted) begin
            exp_gpr = '{1'b1, entry.rs_id, entry.reg_addr, entry.result};
            if (entry.xer_valid) exp_spr = '{1'b1, entry.rs_id, 10'd1, entry.xer};
            if (entry.cr0_valid) exp_cr = '{1'b1, entry.rs_id, cr0_model(entry.result, entry.so)};
        end
        if (row.exp_spr) exp_spr = '{1'b1, spr_in.rs_id, spr_in.addr, spr_in.result};
    endtask

    task automatic report_test(string test, int base);
        if (errors == base) begin
            $display("test %-14s ok", test);
        end else begin
            $display("test %-14s failed with %0d errors", test, errors - base);
            failed_tests++;
        end
    endtask

    initial begin
        wait (table_built);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("Timeout: the run did not reach its end in the allowed time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int base;
        void'($urandom(32'h1730));
        errors       = 0;
        failed_tests = 0;
        rst          = 1'b1;
        // Requests pending through reset feed a valid write-back on every port
        gpr_valid    = '1;
        spr_valid    = 1'b1;
        spr_in       = '0;
        for (int i = 0; i < N; i++) begin
            gpr_in[i]           = '0;
            gpr_in[i].cr0_valid = 1'b1;
        end

        //      name            valid    xer      cr0      spr   mode  ready    spr_ready
        add_row("reset_grant",  4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b1000, 1'b0);
        add_row("rr_unit1",     4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0100, 1'b0);
        add_row("rr_unit2",     4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0010, 1'b0);
        add_row("rr_unit3",     4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0001, 1'b0);
        add_row("rr_wrap",      4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b1000, 1'b0);
        add_row("rr_skip",      4'b1011, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0010, 1'b0);
        add_row("rr_skip_wrap", 4'b1100, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b1000, 1'b0);
        add_row("idle",         4'b0000, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0000, 1'b0);
        add_row("xer_side",     4'b1111, 4'b0100, 4'b0000, 1'b0, 2'd0, 4'b0100, 1'b0);
        add_row("xer_none",     4'b1111, 4'b0100, 4'b0000, 1'b0, 2'd0, 4'b0010, 1'b0);
        add_row("cr0_rand",     4'b1111, 4'b0000, 4'b1111, 1'b0, 2'd0, 4'b0001, 1'b0);
        add_row("cr0_zero",     4'b1111, 4'b0000, 4'b1111, 1'b0, 2'd1, 4'b1000, 1'b0);
        add_row("cr0_neg",      4'b1111, 4'b0000, 4'b1111, 1'b0, 2'd2, 4'b0100, 1'b0);
        add_row("cr0_off",      4'b1111, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0010, 1'b0);
        add_row("cr0_xer",      4'b1111, 4'b1111, 4'b1111, 1'b0, 2'd0, 4'b0001, 1'b0);
        add_row("spr_pair",     4'b1111, 4'b1000, 4'b0000, 1'b1, 2'd0, 4'b0100, 1'b1);
        add_row("spr_turn",     4'b1111, 4'b0000, 4'b0000, 1'b1, 2'd0, 4'b0010, 1'b1);
        add_row("alt_gpr_a",    4'b1111, 4'b1111, 4'b0000, 1'b1, 2'd0, 4'b0001, 1'b0);
        add_row("alt_spr_a",    4'b1111, 4'b1111, 4'b0000, 1'b1, 2'd0, 4'b0000, 1'b1);
        add_row("alt_gpr_b",    4'b1111, 4'b1111, 4'b0000, 1'b1, 2'd0, 4'b1000, 1'b0);
        add_row("alt_spr_b",    4'b1111, 4'b1111, 4'b0000, 1'b1, 2'd0, 4'b0000, 1'b1);
        add_row("spr_alone",    4'b0000, 4'b0000, 4'b0000, 1'b1, 2'd0, 4'b0000, 1'b1);
        add_row("drain",        4'b0000, 4'b0000, 4'b0000, 1'b0, 2'd0, 4'b0000, 1'b0);
        table_built = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_value("reset", "gpr_out.valid", 1'b0, gpr_out.valid);
        compare_value("reset", "spr_out.valid", 1'b0, spr_out.valid);
        compare_value("reset", "cr_out.valid", 1'b0, cr_out.valid);
        report_test("reset", 0);
        gpr_valid = '0;
        spr_valid = 1'b0;

        // Outputs of a row are checked on the falling edge after its grant edge
        for (int k = 0; k <= rows.size(); k++) begin
            @(negedge clk);
            if (k > 0) begin
                compare_port(names[k-1], "gpr_out", exp_gpr.valid, exp_gpr, gpr_out.valid, gpr_out);
                compare_port(names[k-1], "spr_out", exp_spr.valid, exp_spr, spr_out.valid, spr_out);
                compare_port(names[k-1], "cr_out", exp_cr.valid, exp_cr, cr_out.valid, cr_out);
                report_test(names[k-1], base);
            end
            if (k < rows.size()) begin
                base = errors;
                drive_row(rows[k]);
                build_expected(rows[k]);
                #10;
                compare_value(names[k], "gpr_ready", rows[k].exp_ready, gpr_ready);
                compare_value(names[k], "spr_ready", rows[k].exp_spr, spr_ready);
            end
        end

        $display("Tests run %0d, tests failed %0d, mismatches %0d",
                 rows.size() + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/wb_pkg.sv
rtl/wb_turn_fsm.sv
rtl/rr_pointer.sv
rtl/gpr_search.sv
rtl/wb_route.sv
rtl/wb_arbiter_top.sv
tb/tb_wb_arbiter.sv

// File: Bender.yml
package:
  name: wb_arbiter

sources:
  - rtl/wb_pkg.sv
  - rtl/wb_turn_fsm.sv
  - rtl/rr_pointer.sv
  - rtl/gpr_search.sv
  - rtl/wb_route.sv
  - rtl/wb_arbiter_top.sv
  - target: test
    files:
      - tb/tb_wb_arbiter.sv
